// File: rtl/ntm_mac_if.sv
/*
 * Operand pair from the feeder to the MAC lanes, registered in the feeder.
 * Only the lane whose index equals lane_sel acts on a valid pair.
 */

`timescale 1ns/100ps

interface ntm_mac_if #(
  parameter int DATA_SIZE = 16,
  parameter int LANES     = 4
);

  localparam int LANE_W = $clog2(LANES);

  // Pair qualifier
  logic                 op_valid;

  // Matrix element and matching vector element
  logic [DATA_SIZE-1:0] mat;
  logic [DATA_SIZE-1:0] vec;

  // Target lane, row y mod LANES
  logic [LANE_W-1:0]    lane_sel;

  // Row markers
  logic                 row_first;
  logic                 row_last;
  logic                 op_last_row;  // row Y-1 of the operation

  modport feeder (
    output op_valid, mat, vec, lane_sel, row_first, row_last, op_last_row
  );

  modport lane (
    input op_valid, mat, vec, lane_sel, row_first, row_last, op_last_row
  );

endinterface

// File: rtl/ntm_mac_lane.sv
/*
 * One multiply-accumulate lane, products wrap modulo 2**DATA_SIZE.
 * Expects a full row on this lane before the next row_first for it.
 */

`timescale 1ns/100ps

module ntm_mac_lane #(
  parameter int DATA_SIZE  = 16,
  parameter int LANE_INDEX = 0
) (
  input  logic       CLK,
  input  logic       RST,

  ntm_mac_if.lane    mac,
  ntm_result_if.lane res
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic                 sel;
  logic [DATA_SIZE-1:0] prod;
  logic [DATA_SIZE-1:0] acc_next;

  logic [DATA_SIZE-1:0] acc_q;
  logic [DATA_SIZE-1:0] sum_q;
  logic                 final_q;
  logic                 done_q;
  logic                 busy_q;  // row open on this lane

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  assign sel  = mac.op_valid && (mac.lane_sel == LANE_INDEX);

  // Truncated to DATA_SIZE by the assignment
  assign prod = mac.mat * mac.vec;

  // First element of a row starts from zero
  assign acc_next = (mac.row_first ? '0 : acc_q) + prod;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      done_q <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      done_q <= sel && mac.row_last;
      if (sel) begin
        busy_q <= !mac.row_last;
      end
    end
  end

  // Running sum and finished row value
  always_ff @(posedge CLK) begin
    if (sel) begin
      acc_q <= acc_next;
      if (mac.row_last) begin
        sum_q   <= acc_next;
        final_q <= mac.op_last_row;
      end
    end
  end

  // This lane's entries only
  assign res.done[LANE_INDEX]      = done_q;
  assign res.sum[LANE_INDEX]       = sum_q;
  assign res.final_row[LANE_INDEX] = final_q;

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_no_row_overlap: assert property (@(posedge CLK) disable iff (RST)
    (sel && mac.row_first) |-> !busy_q);

endmodule

// File: rtl/ntm_operand_feeder.sv
/*
 * Host streams r and h first, then K and U row by row. No back-pressure.
 * R*W+L must be 1..MAX_VECTOR and Y at least 1. START is ignored unless IDLE.
 */

`timescale 1ns/100ps

module ntm_operand_feeder import ntm_pkg::*; #(
  parameter int DATA_SIZE  = 16,
  parameter int LANES      = 4,
  parameter int MAX_VECTOR = 64
) (
  input  logic                 CLK,
  input  logic                 RST,

  input  logic                 START,
  input  ntm_dims_t            dims,

  input  logic                 R_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] R_IN,
  input  logic                 H_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] H_IN,
  input  logic                 K_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] K_IN,
  input  logic                 U_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] U_IN,

  ntm_mac_if.feeder            mac
);

  localparam int LANE_W = $clog2(LANES);
  localparam int ADDR_W = $clog2(MAX_VECTOR);
  localparam int CNT_W  = $clog2(MAX_VECTOR + 1);
  localparam int LEN_W  = 2 * SIZE_WIDTH + 1;

  //////////////////////////////
  // Signals
  //////////////////////////////

  ntm_feed_state_e      state_q;
  ntm_dims_t            dims_q;

  // Row length split, K part then U part
  logic [LEN_W-1:0]     rw_in;
  logic [LEN_W-1:0]     row_len_in;
  logic [LEN_W-1:0]     rw_q;
  logic [LEN_W-1:0]     row_len_q;

  // Vector load counters
  logic [CNT_W-1:0]     r_cnt;
  logic [CNT_W-1:0]     h_cnt;
  logic [CNT_W-1:0]     r_cnt_next;
  logic [CNT_W-1:0]     h_cnt_next;
  logic                 load_done;

  // Matrix stream position
  logic [CNT_W-1:0]     col_q;
  logic [SIZE_WIDTH-1:0] row_q;
  logic [LANE_W-1:0]    lane_q;

  logic                 start_acc;
  logic                 mat_en;
  logic [DATA_SIZE-1:0] mat_data;
  logic                 col_last;
  logic                 row_last_y;

  // r at i*W+k, h at R*W+l
  logic [DATA_SIZE-1:0] vbuf [MAX_VECTOR];

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign rw_in      = LEN_W'(dims.size_r) * LEN_W'(dims.size_w);
  assign row_len_in = rw_in + LEN_W'(dims.size_l);

  assign start_acc  = START && (state_q == IDLE);

  // Counts including this cycle's elements
  assign r_cnt_next = r_cnt + CNT_W'(R_IN_ENABLE);
  assign h_cnt_next = h_cnt + CNT_W'(H_IN_ENABLE);
  assign load_done  = (LEN_W'(r_cnt_next) == rw_q) && (h_cnt_next == dims_q.size_l);

  // One of K or U per cycle
  assign mat_en     = (K_IN_ENABLE || U_IN_ENABLE) && (state_q == STREAM);
  assign mat_data   = K_IN_ENABLE ? K_IN : U_IN;

  assign col_last   = (LEN_W'(col_q) == row_len_q - 1'b1);
  assign row_last_y = (row_q == dims_q.size_y - 1'b1);

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= IDLE;
      r_cnt        <= '0;
      h_cnt        <= '0;
      col_q        <= '0;
      row_q        <= '0;
      lane_q       <= '0;
      mac.op_valid <= 1'b0;
    end else begin
      mac.op_valid <= mat_en;
      case (state_q)
        IDLE: begin
          if (START) begin
            state_q <= LOAD;
            r_cnt   <= '0;
            h_cnt   <= '0;
            col_q   <= '0;
            row_q   <= '0;
            lane_q  <= '0;
          end
        end
        LOAD: begin
          r_cnt <= r_cnt_next;
          h_cnt <= h_cnt_next;
          if (load_done) begin
            state_q <= STREAM;
          end
        end
        STREAM: begin
          if (mat_en) begin
            if (col_last) begin
              col_q  <= '0;
              row_q  <= row_q + 1'b1;
              lane_q <= (lane_q == LANE_W'(LANES - 1)) ? '0 : lane_q + 1'b1;
              // Done with the last row, lanes drain on their own
              if (row_last_y) begin
                state_q <= IDLE;
              end
            end else begin
              col_q <= col_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Sizes for the whole operation
  always_ff @(posedge CLK) begin
    if (start_acc) begin
      dims_q    <= dims;
      rw_q      <= rw_in;
      row_len_q <= row_len_in;
    end
  end

  // Vector buffer writes, r and h may land together
  always_ff @(posedge CLK) begin
    if (state_q == LOAD) begin
      if (R_IN_ENABLE) begin
        vbuf[ADDR_W'(r_cnt)] <= R_IN;
      end
      if (H_IN_ENABLE) begin
        vbuf[ADDR_W'(rw_q + LEN_W'(h_cnt))] <= H_IN;
      end
    end
  end

  // Operand pair register
  always_ff @(posedge CLK) begin
    if (mat_en) begin
      mac.mat         <= mat_data;
      mac.vec         <= vbuf[ADDR_W'(col_q)];
      mac.lane_sel    <= lane_q;
      mac.row_first   <= (col_q == '0);
      mac.row_last    <= col_last;
      mac.op_last_row <= row_last_y;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_mat_only_in_stream: assert property (@(posedge CLK) disable iff (RST)
    (K_IN_ENABLE || U_IN_ENABLE) |-> (state_q == STREAM));

  a_k_u_exclusive: assert property (@(posedge CLK) disable iff (RST)
    !(K_IN_ENABLE && U_IN_ENABLE));

  a_vector_fits: assert property (@(posedge CLK) disable iff (RST)
    start_acc |-> (row_len_in <= LEN_W'(MAX_VECTOR)));

endmodule

// File: rtl/ntm_output_collector.sv
/*
 * Rows arrive in order, one lane after the other, at most one per cycle.
 * No stall path, so a done pulse is taken in the cycle it appears.
 */

`timescale 1ns/100ps

module ntm_output_collector #(
  parameter int DATA_SIZE = 16,
  parameter int LANES     = 4
) (
  input  logic                 CLK,
  input  logic                 RST,

  ntm_result_if.collector      res,

  output logic                 READY,
  output logic                 Y_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] Y_OUT
);

  localparam int LANE_W = $clog2(LANES);

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic [LANE_W-1:0]    expect_q;  // lane holding the next row
  logic [LANES-1:0]     done_vec;
  logic                 hit;
  logic                 hit_final;
  logic [DATA_SIZE-1:0] hit_sum;

  //////////////////////////////
  // Select
  //////////////////////////////

  // Packed view of the done pulses
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      done_vec[i] = res.done[i];
    end
  end

  assign hit       = res.done[expect_q];
  assign hit_final = res.final_row[expect_q];
  assign hit_sum   = res.sum[expect_q];

  //////////////////////////////
  // Output
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      expect_q     <= '0;
      READY        <= 1'b0;
      Y_OUT_ENABLE <= 1'b0;
      Y_OUT        <= '0;
    end else begin
      Y_OUT_ENABLE <= hit;
      READY        <= hit && hit_final;
      if (hit) begin
        // Y_OUT holds between pulses
        Y_OUT <= hit_sum;
        // Next operation restarts at lane 0
        if (hit_final || (expect_q == LANE_W'(LANES - 1))) begin
          expect_q <= '0;
        end else begin
          expect_q <= expect_q + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_single_done: assert property (@(posedge CLK) disable iff (RST)
    $onehot0(done_vec));

  a_done_in_order: assert property (@(posedge CLK) disable iff (RST)
    (|done_vec) |-> done_vec[expect_q]);

endmodule

// File: rtl/ntm_output_vector.sv
/*
 * y(y) = sum K(i,y,k)*r(i,k) + sum U(y,l)*h(l), unsigned, wrapping.
 * Y_OUT_ENABLE trails the last matrix element of a row by 3 cycles. LANES >= 2.
 */

`timescale 1ns/100ps

module ntm_output_vector import ntm_pkg::*; #(
  parameter int DATA_SIZE  = 16,
  parameter int LANES      = 4,
  parameter int MAX_VECTOR = 64
) (
  // Global
  input  logic                  CLK,
  input  logic                  RST,

  // Control
  input  logic                  START,
  output logic                  READY,

  // Runtime sizes sampled with START
  input  logic [SIZE_WIDTH-1:0] SIZE_Y_IN,
  input  logic [SIZE_WIDTH-1:0] SIZE_L_IN,
  input  logic [SIZE_WIDTH-1:0] SIZE_W_IN,
  input  logic [SIZE_WIDTH-1:0] SIZE_R_IN,

  // Vector load with r ordered i outer and k inner
  input  logic                  R_IN_ENABLE,
  input  logic [DATA_SIZE-1:0]  R_IN,
  input  logic                  H_IN_ENABLE,
  input  logic [DATA_SIZE-1:0]  H_IN,

  // Matrix stream with K then U in each row
  input  logic                  K_IN_ENABLE,
  input  logic [DATA_SIZE-1:0]  K_IN,
  input  logic                  U_IN_ENABLE,
  input  logic [DATA_SIZE-1:0]  U_IN,

  // Result
  output logic                  Y_OUT_ENABLE,
  output logic [DATA_SIZE-1:0]  Y_OUT
);

  ntm_dims_t dims;

  assign dims = '{size_y: SIZE_Y_IN, size_l: SIZE_L_IN,
                  size_w: SIZE_W_IN, size_r: SIZE_R_IN};

  //////////////////////////////
  // Buses
  //////////////////////////////

  ntm_mac_if #(.DATA_SIZE(DATA_SIZE), .LANES(LANES)) mac_bus ();
  ntm_result_if #(.DATA_SIZE(DATA_SIZE), .LANES(LANES)) res_bus ();

  //////////////////////////////
  // Feeder
  //////////////////////////////

  ntm_operand_feeder #(
    .DATA_SIZE (DATA_SIZE),
    .LANES     (LANES),
    .MAX_VECTOR(MAX_VECTOR)
  ) feeder_i (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .dims       (dims),
    .R_IN_ENABLE(R_IN_ENABLE),
    .R_IN       (R_IN),
    .H_IN_ENABLE(H_IN_ENABLE),
    .H_IN       (H_IN),
    .K_IN_ENABLE(K_IN_ENABLE),
    .K_IN       (K_IN),
    .U_IN_ENABLE(U_IN_ENABLE),
    .U_IN       (U_IN),
    .mac        (mac_bus.feeder)
  );

  //////////////////////////////
  // Lanes
  //////////////////////////////

  // Row y lands on lane y mod LANES
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    ntm_mac_lane #(
      .DATA_SIZE (DATA_SIZE),
      .LANE_INDEX(g)
    ) lane_i (
      .CLK(CLK),
      .RST(RST),
      .mac(mac_bus.lane),
      .res(res_bus.lane)
    );
  end

  //////////////////////////////
  // Collector
  //////////////////////////////

  ntm_output_collector #(
    .DATA_SIZE(DATA_SIZE),
    .LANES    (LANES)
  ) collector_i (
    .CLK         (CLK),
    .RST         (RST),
    .res         (res_bus.collector),
    .READY       (READY),
    .Y_OUT_ENABLE(Y_OUT_ENABLE),
    .Y_OUT       (Y_OUT)
  );

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Host starts only between operations
  a_start_when_idle: assert property (@(posedge CLK) disable iff (RST)
    START |-> (feeder_i.state_q == IDLE));

endmodule

// File: rtl/ntm_pkg.sv
/*
 * Shared sizes and types for the NTM output vector datapath.
 * Runtime dimensions are unsigned and SIZE_WIDTH bits wide.
 */

package ntm_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Width of each runtime dimension Y, L, W and R
  localparam int SIZE_WIDTH = 8;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Runtime sizes sampled on START
  typedef struct packed {
    logic [SIZE_WIDTH-1:0] size_y;
    logic [SIZE_WIDTH-1:0] size_l;
    logic [SIZE_WIDTH-1:0] size_w;
    logic [SIZE_WIDTH-1:0] size_r;
  } ntm_dims_t;

  // Feeder phases
  // IDLE    waits for START
  // LOAD    fills the vector buffer with r and h
  // STREAM  pairs K and U elements with buffered vector elements
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    STREAM
  } ntm_feed_state_e;

endpackage

// File: rtl/ntm_result_if.sv
/*
 * Finished rows from the MAC lanes to the collector, one entry per lane.
 * done is a single-cycle pulse with no acknowledge.
 */

`timescale 1ns/100ps

interface ntm_result_if #(
  parameter int DATA_SIZE = 16,
  parameter int LANES     = 4
);

  // Unpacked so that every lane drives only its own entries
  logic                 done      [LANES];
  logic [DATA_SIZE-1:0] sum       [LANES];
  logic                 final_row [LANES];

  modport lane (
    output done, sum, final_row
  );

  modport collector (
    input done, sum, final_row
  );

endinterface

// File: sim.f
+incdir+sim
rtl/ntm_pkg.sv
rtl/ntm_mac_if.sv
rtl/ntm_result_if.sv
rtl/ntm_operand_feeder.sv
rtl/ntm_mac_lane.sv
rtl/ntm_output_collector.sv
rtl/ntm_output_vector.sv
sim/ntm_output_vector_tb.sv

// File: sim/ntm_output_model.svh
/*
 * Reference model and host stimulus, included inside the testbench module.
 * Operand arrays are sized for Y <= 9, L <= 8, W <= 4 and R <= 4.
 */

`ifndef NTM_OUTPUT_MODEL_SVH
`define NTM_OUTPUT_MODEL_SVH

//////////////////////////////
// Operands of one operation
//////////////////////////////

logic [DW-1:0] r_vec [4][4];     // r(i,k)
logic [DW-1:0] h_vec [8];        // h(l)
logic [DW-1:0] k_mat [4][9][4];  // K(i,y,k)
logic [DW-1:0] u_mat [9][8];     // U(y,l)

// Full-range words so that sums overflow
task automatic fill_operands();
  for (int i = 0; i < 4; i++) begin
    for (int k = 0; k < 4; k++)
      r_vec[i][k] = DW'($urandom);
    for (int yy = 0; yy < 9; yy++) begin
      for (int k = 0; k < 4; k++)
        k_mat[i][yy][k] = DW'($urandom);
    end
  end
  for (int l = 0; l < 8; l++)
    h_vec[l] = DW'($urandom);
  for (int yy = 0; yy < 9; yy++) begin
    for (int l = 0; l < 8; l++)
      u_mat[yy][l] = DW'($urandom);
  end
endtask

// y(yy) = sum K(i,yy,k)*r(i,k) + sum U(yy,l)*h(l), wrapped to DW bits
function automatic logic [DW-1:0] model_row(int yy, ntm_dims_t d);
  logic [DW-1:0] acc;
  acc = '0;
  for (int i = 0; i < int'(d.size_r); i++) begin
    for (int k = 0; k < int'(d.size_w); k++)
      acc = acc + k_mat[i][yy][k] * r_vec[i][k];
  end
  for (int l = 0; l < int'(d.size_l); l++)
    acc = acc + u_mat[yy][l] * h_vec[l];
  return acc;
endfunction

// Queue every row in order, READY expected with the last one
task automatic expect_rows(ntm_dims_t d);
  for (int yy = 0; yy < int'(d.size_y); yy++) begin
    exp_vals.push_back(model_row(yy, d));
    exp_last.push_back(yy == int'(d.size_y) - 1);
  end
endtask

//////////////////////////////
// Host stimulus
//////////////////////////////

// All strobes low for this cycle
task automatic drop_strobes();
  START       <= 1'b0;
  R_IN_ENABLE <= 1'b0;
  H_IN_ENABLE <= 1'b0;
  K_IN_ENABLE <= 1'b0;
  U_IN_ENABLE <= 1'b0;
endtask

task automatic idle_cycles(int n);
  repeat (n) begin
    @(posedge CLK);
    drop_strobes();
  end
endtask

// Occasional gap of 1 or 2 cycles
task automatic maybe_gap(bit gaps);
  if (gaps && (pick(0, 3) == 0))
    idle_cycles(pick(1, 2));
endtask

task automatic issue_start(ntm_dims_t d);
  @(posedge CLK);
  drop_strobes();
  START     <= 1'b1;
  SIZE_Y_IN <= d.size_y;
  SIZE_L_IN <= d.size_l;
  SIZE_W_IN <= d.size_w;
  SIZE_R_IN <= d.size_r;
endtask

// r in order i outer and k inner, h interleaved at random
task automatic load_vectors(ntm_dims_t d, bit gaps);
  int rw;
  int ri;
  int hi;
  int way;
  bit send_r;
  bit send_h;
  rw = int'(d.size_r) * int'(d.size_w);
  ri = 0;
  hi = 0;
  while ((ri < rw) || (hi < int'(d.size_l))) begin
    @(posedge CLK);
    drop_strobes();
    // 0 r only, 1 h only, 2 both
    way    = pick(0, 2);
    send_r = (ri < rw) && ((way != 1) || (hi >= int'(d.size_l)));
    send_h = (hi < int'(d.size_l)) && ((way != 0) || (ri >= rw));
    if (send_r) begin
      R_IN_ENABLE <= 1'b1;
      R_IN        <= r_vec[ri / int'(d.size_w)][ri % int'(d.size_w)];
      ri++;
    end
    if (send_h) begin
      H_IN_ENABLE <= 1'b1;
      H_IN        <= h_vec[hi];
      hi++;
    end
    maybe_gap(gaps);
  end
endtask

// Per row R*W K elements then L U elements
task automatic stream_rows(ntm_dims_t d, bit gaps);
  int rw;
  rw = int'(d.size_r) * int'(d.size_w);
  for (int yy = 0; yy < int'(d.size_y); yy++) begin
    for (int j = 0; j < rw; j++) begin
      @(posedge CLK);
      drop_strobes();
      K_IN_ENABLE <= 1'b1;
      K_IN        <= k_mat[j / int'(d.size_w)][yy][j % int'(d.size_w)];
      if ((d.size_l == 0) && (j == rw - 1))
        exp_times.push_back($time + ROW_LATENCY);
      maybe_gap(gaps);
    end
    for (int l = 0; l < int'(d.size_l); l++) begin
      @(posedge CLK);
      drop_strobes();
      U_IN_ENABLE <= 1'b1;
      U_IN        <= u_mat[yy][l];
      if (l == int'(d.size_l) - 1)
        exp_times.push_back($time + ROW_LATENCY);
      maybe_gap(gaps);
    end
  end
endtask

`endif

// File: sim/ntm_output_vector_tb.sv
/*
 * Random NTM output vector operations against a model, seed 40, default DUT.
 * Stops at the first wrong value, wrong pulse time or timeout.
 */

`timescale 1ns/100ps

module ntm_output_vector_tb import ntm_pkg::*; ();

  localparam int DW         = 16;
  localparam int N_OPS      = 40;
  localparam int CLK_PERIOD = 20;
  // Drive edge to the negedge inside the Y_OUT_ENABLE cycle
  localparam int ROW_LATENCY = 3 * CLK_PERIOD + CLK_PERIOD / 2;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic                  CLK;
  logic                  RST;
  logic                  START;
  logic [SIZE_WIDTH-1:0] SIZE_Y_IN;
  logic [SIZE_WIDTH-1:0] SIZE_L_IN;
  logic [SIZE_WIDTH-1:0] SIZE_W_IN;
  logic [SIZE_WIDTH-1:0] SIZE_R_IN;
  logic                  R_IN_ENABLE;
  logic [DW-1:0]         R_IN;
  logic                  H_IN_ENABLE;
  logic [DW-1:0]         H_IN;
  logic                  K_IN_ENABLE;
  logic [DW-1:0]         K_IN;
  logic                  U_IN_ENABLE;
  logic [DW-1:0]         U_IN;
  logic                  READY;
  logic                  Y_OUT_ENABLE;
  logic [DW-1:0]         Y_OUT;

  // Expected row values, READY flags and pulse times
  logic [DW-1:0] exp_vals  [$];
  bit            exp_last  [$];
  time           exp_times [$];

  ntm_dims_t     ops     [N_OPS];
  bit            op_gaps [N_OPS];

  int unsigned   cyc = 0;
  int unsigned   cyc_limit;
  int            errors = 0;

  logic [DW-1:0] mon_val;
  bit            mon_last;
  time           mon_time;

  function automatic int unsigned pick(int unsigned lo, int unsigned hi);
    return lo + ($urandom % (hi - lo + 1));
  endfunction

  task automatic report_mismatch(string name, longint unsigned exp_v, longint unsigned act_v);
    errors++;
    $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_failure(string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  `include "ntm_output_model.svh"

  ntm_output_vector dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Sizes for all operations and the cycle budget they need
  function automatic void plan_operations();
    int unsigned elems;
    cyc_limit = 40;
    for (int n = 0; n < N_OPS; n++) begin
      // Every fifth operation is one-element rows back to back
      if (n % 5 == 2) begin
        ops[n]     = '{size_y: 8'd9, size_l: 8'd0, size_w: 8'd1, size_r: 8'd1};
        op_gaps[n] = 1'b0;
      end else begin
        ops[n].size_y = SIZE_WIDTH'(pick(1, 9));
        ops[n].size_l = SIZE_WIDTH'(pick(0, 8));
        ops[n].size_w = SIZE_WIDTH'(pick(1, 4));
        ops[n].size_r = SIZE_WIDTH'(pick(1, 4));
        op_gaps[n]    = bit'(pick(0, 1));
      end
      elems = (ops[n].size_r * ops[n].size_w + ops[n].size_l) * (ops[n].size_y + 1);
      // Up to 2 gap cycles per element
      cyc_limit += 3 * elems + 20;
    end
  endfunction

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(40));
    RST       <= 1'b1;
    SIZE_Y_IN <= '0;
    SIZE_L_IN <= '0;
    SIZE_W_IN <= '0;
    SIZE_R_IN <= '0;
    R_IN      <= '0;
    H_IN      <= '0;
    K_IN      <= '0;
    U_IN      <= '0;
    drop_strobes();
    plan_operations();
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    // Outputs stay quiet until the first START
    repeat (4) begin
      @(negedge CLK);
      assert (Y_OUT === '0) else report_mismatch("Y_OUT", 0, Y_OUT);
      assert (Y_OUT_ENABLE === 1'b0) else report_mismatch("Y_OUT_ENABLE", 0, Y_OUT_ENABLE);
      assert (READY === 1'b0) else report_mismatch("READY", 0, READY);
    end

    for (int n = 0; n < N_OPS; n++) begin
      fill_operands();
      expect_rows(ops[n]);
      issue_start(ops[n]);
      load_vectors(ops[n], op_gaps[n]);
      stream_rows(ops[n], op_gaps[n]);
      // Without gaps the next START follows the last element directly
      if (op_gaps[n])
        idle_cycles(pick(0, 2));
    end
    idle_cycles(1);

    while (exp_vals.size() != 0)
      @(negedge CLK);
    // Room for any stray pulse
    repeat (8) @(negedge CLK);

    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (Y_OUT_ENABLE) begin
        assert ((exp_vals.size() != 0) && (exp_times.size() != 0))
          else report_failure("Y_OUT_ENABLE pulse with no row outstanding");
        if ((exp_vals.size() != 0) && (exp_times.size() != 0)) begin
          mon_val  = exp_vals.pop_front();
          mon_last = exp_last.pop_front();
          mon_time = exp_times.pop_front();
          assert (Y_OUT === mon_val) else report_mismatch("Y_OUT", mon_val, Y_OUT);
          assert (READY === mon_last) else report_mismatch("READY", mon_last, READY);
          assert ($time == mon_time)
            else report_mismatch("Y_OUT_ENABLE time", mon_time, $time);
        end
      end else begin
        // READY only with the final row
        assert (READY === 1'b0) else report_mismatch("READY", 0, READY);
      end
    end
  end

  // Run length limit
  always @(posedge CLK) begin
    cyc <= cyc + 1;
    assert (cyc < cyc_limit) else report_failure("timeout, operations did not complete");
  end

endmodule
